//--- Makefile
TOP := mem_stage_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --top-module $(TOP) -f vlog.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- data_sram.sv
`default_nettype none
`timescale 1ns/100ps

module data_sram (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             req_i,
    input  logic                             we_i,
    input  logic [mem_stage_pkg::DMEM_AW-1:0] addr_i,
    input  logic [3:0]                       wmask_i,
    input  logic [31:0]                      wdata_i,
    output logic                             ack_o,
    output logic [31:0]                      rdata_o
);

    logic [31:0] mem [mem_stage_pkg::DMEM_WORDS];
    logic        start;

    // new request, previous one fully released
    assign start = req_i && !ack_o;

    // ack rises the cycle after req, falls the cycle after req drops
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else if (start) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    // byte-lane write
    always_ff @(posedge clk) begin
        if (start && we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask_i[i]) begin
                    mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // read word, held until the next access
    always_ff @(posedge clk) begin
        if (start && !we_i) begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

`default_nettype wire

//--- load_align.sv
`default_nettype none
`timescale 1ns/100ps

module load_align (
    input  mem_stage_pkg::mem_op_e op_i,
    input  logic [1:0]             addr_lo_i,
    input  logic [31:0]            rdata_i,
    input  logic [31:0]            alu_result_i,
    output logic [31:0]            result_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // addressed byte and halfword of the read word
    always_comb begin
        case (addr_lo_i)
            2'b00: byte_sel = rdata_i[7:0];
            2'b01: byte_sel = rdata_i[15:8];
            2'b10: byte_sel = rdata_i[23:16];
            default: byte_sel = rdata_i[31:24];
        endcase
    end

    assign half_sel = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (op_i)
            mem_stage_pkg::OP_LB:  result_o = {{24{byte_sel[7]}}, byte_sel};
            mem_stage_pkg::OP_LBU: result_o = {24'h0, byte_sel};
            mem_stage_pkg::OP_LH:  result_o = {{16{half_sel[15]}}, half_sel};
            mem_stage_pkg::OP_LHU: result_o = {16'h0, half_sel};
            mem_stage_pkg::OP_LW:  result_o = rdata_i;
            // stores and non-memory ops pass the alu value on
            default: result_o = alu_result_i;
        endcase
    end

endmodule

`default_nettype wire

//--- mem_access_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module mem_access_ctrl (
    input  logic        clk,
    input  logic        rst_n_i,
    // upstream handshake
    input  logic        in_valid_i,
    output logic        in_ready_o,
    // decode results
    input  logic        is_mem_i,
    input  logic        is_store_i,
    input  logic        misalign_i,
    input  logic [4:0]  wreg_idx_i,
    input  logic        wreg_en_i,
    input  logic        flush_i,
    // four-phase memory handshake
    output logic        mem_req_o,
    output logic        mem_we_o,
    input  logic        mem_ack_i,
    // aligned load data or alu result
    input  logic [31:0] result_i,
    // downstream handshake and payload
    output logic        wb_valid_o,
    input  logic        wb_ready_i,
    output logic [31:0] wb_data_o,
    output logic [4:0]  wb_reg_o,
    output logic        wb_we_o,
    output logic        wb_excp_o
);

    mem_stage_pkg::mem_state_e state_q;
    mem_stage_pkg::mem_state_e state_d;
    logic direct;
    logic hs_done;
    logic load_out;

    // no memory cycle for these, the result is ready at once
    assign direct = !is_mem_i || misalign_i;

    // ack has fallen after the release, handshake complete
    assign hs_done = (state_q == mem_stage_pkg::ST_RELEASE) && !mem_ack_i;

    // memory items are accepted only when their handshake ends
    assign in_ready_o = ((state_q == mem_stage_pkg::ST_IDLE) && in_valid_i && direct) ||
                        hs_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_stage_pkg::ST_IDLE: begin
                if (in_valid_i) begin
                    if (!direct) begin
                        state_d = mem_stage_pkg::ST_REQ;
                    end else if (!flush_i) begin
                        state_d = mem_stage_pkg::ST_OUT;
                    end
                end
            end
            mem_stage_pkg::ST_REQ: begin
                if (mem_ack_i) begin
                    state_d = mem_stage_pkg::ST_RELEASE;
                end
            end
            mem_stage_pkg::ST_RELEASE: begin
                // a result finishing during flush is dropped
                if (!mem_ack_i) begin
                    state_d = flush_i ? mem_stage_pkg::ST_IDLE : mem_stage_pkg::ST_OUT;
                end
            end
            default: begin
                if (wb_ready_i || flush_i) begin
                    state_d = mem_stage_pkg::ST_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= mem_stage_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign mem_req_o = (state_q == mem_stage_pkg::ST_REQ);
    assign mem_we_o = mem_req_o && is_store_i;

    // rdata is only valid with ack, so memory results are taken there
    assign load_out = ((state_q == mem_stage_pkg::ST_IDLE) && in_valid_i && direct) ||
                      (mem_req_o && mem_ack_i);

    always_ff @(posedge clk) begin
        if (load_out) begin
            wb_data_o <= result_i;
            wb_reg_o <= wreg_idx_i;
            wb_we_o <= wreg_en_i && !misalign_i;
            wb_excp_o <= misalign_i;
        end
    end

    assign wb_valid_o = (state_q == mem_stage_pkg::ST_OUT);

endmodule

`default_nettype wire

//--- mem_op_decode.sv
`default_nettype none
`timescale 1ns/100ps

module mem_op_decode (
    input  mem_stage_pkg::mem_op_e op_i,
    input  logic [31:0]            addr_i,
    input  logic [31:0]            store_data_i,
    output logic                   is_mem_o,
    output logic                   is_store_o,
    output logic                   misalign_o,
    output logic [3:0]             wmask_o,
    output logic [31:0]            wdata_o
);

    logic is_byte;
    logic is_half;
    logic is_word;

    // access size classification
    assign is_byte = (op_i == mem_stage_pkg::OP_LB) || (op_i == mem_stage_pkg::OP_LBU) ||
                     (op_i == mem_stage_pkg::OP_SB);
    assign is_half = (op_i == mem_stage_pkg::OP_LH) || (op_i == mem_stage_pkg::OP_LHU) ||
                     (op_i == mem_stage_pkg::OP_SH);
    assign is_word = (op_i == mem_stage_pkg::OP_LW) || (op_i == mem_stage_pkg::OP_SW);

    assign is_mem_o = is_byte || is_half || is_word;
    assign is_store_o = (op_i == mem_stage_pkg::OP_SB) || (op_i == mem_stage_pkg::OP_SH) ||
                        (op_i == mem_stage_pkg::OP_SW);

    // halfwords need bit 0 clear, words need both low bits clear
    assign misalign_o = (is_half && addr_i[0]) || (is_word && (addr_i[1:0] != 2'b00));

    // lane mask and store data moved into the addressed lane
    always_comb begin
        wmask_o = 4'b0000;
        wdata_o = store_data_i;
        if (is_byte) begin
            case (addr_i[1:0])
                2'b00: wmask_o = 4'b0001;
                2'b01: wmask_o = 4'b0010;
                2'b10: wmask_o = 4'b0100;
                default: wmask_o = 4'b1000;
            endcase
            wdata_o = {24'h0, store_data_i[7:0]} << {addr_i[1:0], 3'b000};
        end else if (is_half) begin
            if (addr_i[1]) begin
                wmask_o = 4'b1100;
                wdata_o = {store_data_i[15:0], 16'h0};
            end else begin
                wmask_o = 4'b0011;
                wdata_o = {16'h0, store_data_i[15:0]};
            end
        end else if (is_word) begin
            wmask_o = 4'b1111;
        end
    end

endmodule

`default_nettype wire

//--- mem_stage_asserts.sv
`default_nettype none
`timescale 1ns/100ps

module mem_stage_asserts (
    input logic        clk,
    input logic        rst_n_i,
    input logic        mem_req_i,
    input logic        mem_ack_i,
    input logic        flush_i,
    input logic        wb_valid_i,
    input logic        wb_ready_i,
    input logic [31:0] wb_data_i,
    input logic [4:0]  wb_reg_i,
    input logic        wb_we_i,
    input logic        wb_excp_i
);

    // a new request only after the previous ack has fallen
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(mem_req_i) |-> !mem_ack_i)
        else $error("mem_req rose while mem_ack was high");

    // an open request is not withdrawn before the sram answers
    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i && !mem_ack_i |=> mem_req_i)
        else $error("mem_req dropped before mem_ack");

    // output register frozen while writeback stalls
    wb_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_i && !wb_ready_i && !flush_i |=>
            wb_valid_i && $stable(wb_data_i) && $stable({wb_reg_i, wb_we_i, wb_excp_i}))
        else $error("writeback output changed under back-pressure");

endmodule

bind mem_access_ctrl mem_stage_asserts u_asserts (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .mem_req_i  (mem_req_o),
    .mem_ack_i  (mem_ack_i),
    .flush_i    (flush_i),
    .wb_valid_i (wb_valid_o),
    .wb_ready_i (wb_ready_i),
    .wb_data_i  (wb_data_o),
    .wb_reg_i   (wb_reg_o),
    .wb_we_i    (wb_we_o),
    .wb_excp_i  (wb_excp_o)
);

`default_nettype wire

//--- mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // data memory geometry
    // word index is taken from address bits [DMEM_AW+1:2]
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW = 8;

    // memory operation carried with every instruction from execute
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        // loads, signed and unsigned
        OP_LB   = 4'd1,
        OP_LBU  = 4'd2,
        OP_LH   = 4'd3,
        OP_LHU  = 4'd4,
        OP_LW   = 4'd5,
        // stores
        OP_SB   = 4'd6,
        OP_SH   = 4'd7,
        OP_SW   = 4'd8
    } mem_op_e;

    // stage control FSM states
    typedef enum logic [1:0] {
        // waiting for an instruction, output register empty
        ST_IDLE    = 2'd0,
        // mem_req high, waiting for mem_ack
        ST_REQ     = 2'd1,
        // mem_req dropped, waiting for mem_ack to fall
        ST_RELEASE = 2'd2,
        // result held in the output register
        ST_OUT     = 2'd3
    } mem_state_e;

endpackage

`default_nettype wire

//--- mem_stage_tb.sv
`default_nettype none
`timescale 1ns/100ps

module mem_stage_tb;

    localparam int NUM_INSTR = 80;
    localparam int BP_LEN = 24;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    logic                   flush_i;
    logic                   in_valid_i;
    logic [31:0]            alu_result_i;
    logic [31:0]            store_data_i;
    mem_stage_pkg::mem_op_e op_i;
    logic [4:0]             wreg_idx_i;
    logic                   wreg_en_i;
    logic                   in_ready_o;
    logic                   wb_valid_o;
    logic [31:0]            wb_data_o;
    logic [4:0]             wb_reg_o;
    logic                   wb_we_o;
    logic                   wb_excp_o;
    logic                   wb_ready_i;

    // mirror of the data memory, written by every store issued
    logic [31:0] ref_mem [mem_stage_pkg::DMEM_WORDS];
    int data_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;

    // mixed sequence for the back-pressure run
    mem_stage_pkg::mem_op_e seq_op [BP_LEN];
    logic [31:0] seq_addr [BP_LEN];
    logic [31:0] seq_wdata [BP_LEN];
    logic [31:0] seq_exp [BP_LEN];
    logic        seq_we [BP_LEN];
    logic        seq_excp [BP_LEN];
    logic        seq_chk [BP_LEN];

    mem_stage_top dut0 (.*);

    always #5 clk = ~clk;

    function automatic logic misaligned(mem_stage_pkg::mem_op_e op, logic [31:0] addr);
        case (op)
            mem_stage_pkg::OP_LH, mem_stage_pkg::OP_LHU, mem_stage_pkg::OP_SH: return addr[0];
            mem_stage_pkg::OP_LW, mem_stage_pkg::OP_SW: return addr[1:0] != 2'b00;
            default: return 1'b0;
        endcase
    endfunction

    // expected writeback of one instruction, stores update the mirror
    task automatic predict(input mem_stage_pkg::mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic en,
                           output logic [31:0] exp_data, output logic we,
                           output logic excp, output logic chk);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = ref_mem[addr[mem_stage_pkg::DMEM_AW+1:2]];
        b = word[{addr[1:0], 3'b000} +: 8];
        h = word[{addr[1], 4'b0000} +: 16];
        excp = misaligned(op, addr);
        we = en && !excp;
        chk = !excp;
        exp_data = addr;
        if (!excp) begin
            case (op)
                mem_stage_pkg::OP_LB:  exp_data = {{24{b[7]}}, b};
                mem_stage_pkg::OP_LBU: exp_data = {24'h0, b};
                mem_stage_pkg::OP_LH:  exp_data = {{16{h[15]}}, h};
                mem_stage_pkg::OP_LHU: exp_data = {16'h0, h};
                mem_stage_pkg::OP_LW:  exp_data = word;
                mem_stage_pkg::OP_SB:  word[{addr[1:0], 3'b000} +: 8] = wdata[7:0];
                mem_stage_pkg::OP_SH:  word[{addr[1], 4'b0000} +: 16] = wdata[15:0];
                mem_stage_pkg::OP_SW:  word = wdata;
                default: ;
            endcase
            ref_mem[addr[mem_stage_pkg::DMEM_AW+1:2]] = word;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            data_errors++;
            $display("Fail at %0d ns: %s expected %08h, got %08h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic compare_flags(input logic exp_we, input logic exp_excp,
                                 input logic [4:0] exp_reg, input logic act_we,
                                 input logic act_excp, input logic [4:0] act_reg);
        if ({act_we, act_excp, act_reg} !== {exp_we, exp_excp, exp_reg}) begin
            flag_errors++;
            $display("Fail at %0d ns: wb_we_o/wb_excp_o/wb_reg_o expected %b/%b/%0d, got %b/%b/%0d",
                     $time, exp_we, exp_excp, exp_reg, act_we, act_excp, act_reg);
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send(input mem_stage_pkg::mem_op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [4:0] rg, input logic en);
        logic taken;
        op_i = op;
        alu_result_i = addr;
        store_data_i = wdata;
        wreg_idx_i = rg;
        wreg_en_i = en;
        in_valid_i = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            #1;
            taken = in_ready_o;
            @(negedge clk);
        end
        in_valid_i = 1'b0;
    endtask

    task automatic collect(input logic random_ready, output logic [31:0] data,
                           output logic we, output logic excp, output logic [4:0] rg);
        logic done;
        done = 1'b0;
        while (!done) begin
            wb_ready_i = random_ready ? ($urandom_range(1, 0) != 0) : 1'b1;
            #1;
            if (wb_valid_o && wb_ready_i) begin
                data = wb_data_o;
                we = wb_we_o;
                excp = wb_excp_o;
                rg = wb_reg_o;
                done = 1'b1;
            end
            @(negedge clk);
        end
        wb_ready_i = 1'b0;
    endtask

    task automatic run_one(input mem_stage_pkg::mem_op_e op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [4:0] rg, input logic en);
        logic [31:0] exp_data;
        logic        exp_we;
        logic        exp_excp;
        logic        chk;
        logic [31:0] got;
        logic        got_we;
        logic        got_excp;
        logic [4:0]  got_reg;
        predict(op, addr, wdata, en, exp_data, exp_we, exp_excp, chk);
        send(op, addr, wdata, rg, en);
        collect(1'b0, got, got_we, got_excp, got_reg);
        if (chk) begin
            compare_word("wb_data_o", exp_data, got);
        end
        compare_flags(exp_we, exp_excp, rg, got_we, got_excp, got_reg);
    endtask

    task automatic pass_through();
        for (int i = 0; i < 4; i++) begin
            run_one(mem_stage_pkg::OP_NONE, $urandom(), 32'h0, 5'(i + 1), i[0]);
        end
    endtask

    task automatic word_store_load();
        logic [31:0] addrs [4];
        addrs = '{32'h000, 32'h0a4, 32'h1f0, 32'h3fc};
        for (int i = 0; i < 4; i++) begin
            run_one(mem_stage_pkg::OP_SW, addrs[i], $urandom(), 5'd0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            run_one(mem_stage_pkg::OP_LW, addrs[i], 32'h0, 5'(i + 8), 1'b1);
        end
    endtask

    task automatic byte_half_lanes();
        logic [31:0] addr;
        logic [31:0] wdata;
        for (int lane = 0; lane < 4; lane++) begin
            addr = 32'h100 + 32'(lane * 4);
            run_one(mem_stage_pkg::OP_SW, addr, $urandom(), 5'd0, 1'b0);
            wdata = $urandom();
            // odd lanes carry a negative byte
            wdata[7] = lane[0];
            addr = addr + 32'(lane);
            run_one(mem_stage_pkg::OP_SB, addr, wdata, 5'd0, 1'b0);
            run_one(mem_stage_pkg::OP_LB, addr, 32'h0, 5'd1, 1'b1);
            run_one(mem_stage_pkg::OP_LBU, addr, 32'h0, 5'd2, 1'b1);
            run_one(mem_stage_pkg::OP_LW, addr & ~32'h3, 32'h0, 5'd3, 1'b1);
        end
        for (int half = 0; half < 2; half++) begin
            addr = 32'h120 + 32'(half * 4);
            run_one(mem_stage_pkg::OP_SW, addr, $urandom(), 5'd0, 1'b0);
            wdata = $urandom();
            wdata[15] = half[0];
            addr = addr + 32'(half * 2);
            run_one(mem_stage_pkg::OP_SH, addr, wdata, 5'd0, 1'b0);
            run_one(mem_stage_pkg::OP_LH, addr, 32'h0, 5'd1, 1'b1);
            run_one(mem_stage_pkg::OP_LHU, addr, 32'h0, 5'd2, 1'b1);
            run_one(mem_stage_pkg::OP_LW, addr & ~32'h3, 32'h0, 5'd3, 1'b1);
        end
    endtask

    task automatic misaligned_access();
        run_one(mem_stage_pkg::OP_SW, 32'h140, $urandom(), 5'd0, 1'b0);
        run_one(mem_stage_pkg::OP_LH, 32'h141, 32'h0, 5'd4, 1'b1);
        run_one(mem_stage_pkg::OP_LHU, 32'h143, 32'h0, 5'd4, 1'b1);
        run_one(mem_stage_pkg::OP_LW, 32'h142, 32'h0, 5'd4, 1'b1);
        run_one(mem_stage_pkg::OP_LW, 32'h141, 32'h0, 5'd4, 1'b1);
        run_one(mem_stage_pkg::OP_SH, 32'h141, $urandom(), 5'd5, 1'b1);
        run_one(mem_stage_pkg::OP_SW, 32'h142, $urandom(), 5'd6, 1'b1);
        // word at 0x140 must be untouched
        run_one(mem_stage_pkg::OP_LW, 32'h140, 32'h0, 5'd7, 1'b1);
    endtask

    task automatic random_back_pressure();
        logic [31:0] got;
        logic        got_we;
        logic        got_excp;
        logic [4:0]  got_reg;
        for (int i = 0; i < BP_LEN; i++) begin
            if (i < 4) begin
                seq_op[i] = mem_stage_pkg::OP_SW;
                seq_addr[i] = 32'h200 + 32'(i * 4);
            end else begin
                seq_op[i] = mem_stage_pkg::mem_op_e'(4'($urandom_range(8, 0)));
                seq_addr[i] = 32'h200 | $urandom_range(15, 0);
            end
            seq_wdata[i] = $urandom();
            predict(seq_op[i], seq_addr[i], seq_wdata[i], 1'b1,
                    seq_exp[i], seq_we[i], seq_excp[i], seq_chk[i]);
        end
        fork
            begin
                for (int i = 0; i < BP_LEN; i++) begin
                    send(seq_op[i], seq_addr[i], seq_wdata[i], 5'(i), 1'b1);
                end
            end
            begin
                for (int j = 0; j < BP_LEN; j++) begin
                    collect(1'b1, got, got_we, got_excp, got_reg);
                    if (seq_chk[j]) begin
                        compare_word("wb_data_o", seq_exp[j], got);
                    end
                    compare_flags(seq_we[j], seq_excp[j], 5'(j), got_we, got_excp, got_reg);
                end
            end
        join
    endtask

    task automatic flush_held_result();
        logic [31:0] alu;
        alu = $urandom();
        send(mem_stage_pkg::OP_NONE, alu, 32'h0, 5'd9, 1'b1);
        @(negedge clk);
        flush_i = 1'b1;
        #1;
        if (!wb_valid_o) begin
            other_errors++;
            $display("Fail at %0d ns: wb_valid_o expected 1, got 0 under back-pressure", $time);
        end
        @(negedge clk);
        flush_i = 1'b0;
        #1;
        if (wb_valid_o) begin
            other_errors++;
            $display("Fail at %0d ns: wb_valid_o expected 0, got 1 after flush", $time);
        end
        @(negedge clk);
        run_one(mem_stage_pkg::OP_NONE, ~alu, 32'h0, 5'd10, 1'b1);
    endtask

    // allows 20 cycles per instruction plus reset and slack
    initial begin
        repeat (NUM_INSTR * 20 + 200) @(posedge clk);
        $display("timeout: the DUT stopped answering before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hc2667786));
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        in_valid_i = 1'b0;
        alu_result_i = 32'h0;
        store_data_i = 32'h0;
        op_i = mem_stage_pkg::OP_NONE;
        wreg_idx_i = 5'd0;
        wreg_en_i = 1'b0;
        wb_ready_i = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        pass_through();
        word_store_load();
        byte_half_lanes();
        misaligned_access();
        random_back_pressure();
        flush_held_result();
        $display("errors: data %0d, flags %0d, other %0d", data_errors, flag_errors, other_errors);
        if (data_errors + flag_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_stage_top.sv
`default_nettype none
`timescale 1ns/100ps

module mem_stage_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    // from execute
    input  logic                   in_valid_i,
    input  logic [31:0]            alu_result_i,
    input  logic [31:0]            store_data_i,
    input  mem_stage_pkg::mem_op_e op_i,
    input  logic [4:0]             wreg_idx_i,
    input  logic                   wreg_en_i,
    output logic                   in_ready_o,
    // to writeback
    output logic                   wb_valid_o,
    output logic [31:0]            wb_data_o,
    output logic [4:0]             wb_reg_o,
    output logic                   wb_we_o,
    output logic                   wb_excp_o,
    input  logic                   wb_ready_i
);

    logic        is_mem;
    logic        is_store;
    logic        misalign;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_wdata;
    logic        mem_req;
    logic        mem_we;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic [31:0] ld_result;

    mem_op_decode u_decode (
        .op_i         (op_i),
        .addr_i       (alu_result_i),
        .store_data_i (store_data_i),
        .is_mem_o     (is_mem),
        .is_store_o   (is_store),
        .misalign_o   (misalign),
        .wmask_o      (mem_wmask),
        .wdata_o      (mem_wdata)
    );

    mem_access_ctrl u_ctrl (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .is_mem_i   (is_mem),
        .is_store_i (is_store),
        .misalign_i (misalign),
        .wreg_idx_i (wreg_idx_i),
        .wreg_en_i  (wreg_en_i),
        .flush_i    (flush_i),
        .mem_req_o  (mem_req),
        .mem_we_o   (mem_we),
        .mem_ack_i  (mem_ack),
        .result_i   (ld_result),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_data_o  (wb_data_o),
        .wb_reg_o   (wb_reg_o),
        .wb_we_o    (wb_we_o),
        .wb_excp_o  (wb_excp_o)
    );

    load_align u_align (
        .op_i         (op_i),
        .addr_lo_i    (alu_result_i[1:0]),
        .rdata_i      (mem_rdata),
        .alu_result_i (alu_result_i),
        .result_o     (ld_result)
    );

    // word index from address bits 9:2
    data_sram u_sram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (mem_req),
        .we_i    (mem_we),
        .addr_i  (alu_result_i[mem_stage_pkg::DMEM_AW+1:2]),
        .wmask_i (mem_wmask),
        .wdata_i (mem_wdata),
        .ack_o   (mem_ack),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

//--- vlog.f
mem_stage_pkg.sv
mem_op_decode.sv
mem_access_ctrl.sv
load_align.sv
data_sram.sv
mem_stage_top.sv
mem_stage_asserts.sv
mem_stage_tb.sv
